// ==== Makefile ====
TOP := rvv_backend_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

obj_dir/V$(TOP): compile.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
design/rvv_pkg.sv
design/rvv_fifo.sv
design/rvv_decode.sv
design/rvv_dispatch.sv
design/rvv_alu.sv
design/rvv_rob.sv
design/rvv_vrf.sv
design/rvv_backend.sv
dv/rvv_backend_asserts.sv
dv/rvv_backend_tb.sv

// ==== design/rvv_alu.sv ====
`timescale 1ns/1ps

module rvv_alu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rs_valid,
    input  rvv_pkg::alu_uop_t              rs_uop,
    output logic                           rs_ready,
    output logic                           wb_valid,
    output logic [rvv_pkg::ROB_IDX_W-1:0]  wb_idx,
    output rvv_pkg::vreg_t                 wb_data
);

    import rvv_pkg::*;

    function automatic vreg_t alu_calc(alu_op_e op, vreg_t vs2, vreg_t vs1);
        vreg_t             res;
        logic [ELEM_W-1:0] a;
        logic [ELEM_W-1:0] b;
        res = '0;
        for (int i = 0; i < NUM_ELEM; i++) begin
            a = vs2[i*ELEM_W +: ELEM_W];
            b = vs1[i*ELEM_W +: ELEM_W];
            case (op)
                ALU_ADD:  res[i*ELEM_W +: ELEM_W] = a + b;
                ALU_SUB:  res[i*ELEM_W +: ELEM_W] = a - b;
                ALU_AND:  res[i*ELEM_W +: ELEM_W] = a & b;
                ALU_OR:   res[i*ELEM_W +: ELEM_W] = a | b;
                ALU_XOR:  res[i*ELEM_W +: ELEM_W] = a ^ b;
                ALU_MINU: res[i*ELEM_W +: ELEM_W] = (a < b) ? a : b;
                ALU_MAXU: res[i*ELEM_W +: ELEM_W] = (a > b) ? a : b;
                default:  res[i*ELEM_W +: ELEM_W] = '0;
            endcase
        end
        return res;
    endfunction

    // Write-back never stalls
    assign rs_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rs_valid) begin
            wb_idx  <= rs_uop.rob_idx;
            wb_data <= alu_calc(rs_uop.op, rs_uop.vs2_data, rs_uop.vs1_data);
        end
    end

endmodule

// ==== design/rvv_backend.sv ====
`timescale 1ns/1ps

module rvv_backend #(
    parameter int CQ_DEPTH = rvv_pkg::CQ_DEPTH_DEF,
    parameter int UQ_DEPTH = rvv_pkg::UQ_DEPTH_DEF,
    parameter int RS_DEPTH = rvv_pkg::RS_DEPTH_DEF
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            inst_valid,
    input  logic [rvv_pkg::INST_W-1:0]      inst,
    output logic                            inst_ready,
    output logic                            rt_valid,
    output logic [rvv_pkg::VREG_IDX_W-1:0]  rt_vd,
    output rvv_pkg::vreg_t                  rt_data,
    output logic                            rt_illegal,
    input  logic                            rt_ready
);

    import rvv_pkg::*;

    logic                  cq_valid;
    logic [INST_W-1:0]     cq_inst;
    logic                  cq_ready;
    logic                  de_valid;
    uop_t                  de_uop;
    logic                  de_ready;
    logic                  uq_valid;
    uop_t                  uq_uop;
    logic                  uq_ready;
    logic [VREG_IDX_W-1:0] rd_idx_a;
    logic [VREG_IDX_W-1:0] rd_idx_b;
    vreg_t                 rd_data_a;
    vreg_t                 rd_data_b;
    logic [NUM_VREG-1:0]   pend_mask;
    logic                  alloc_valid;
    logic [VREG_IDX_W-1:0] alloc_vd;
    logic                  alloc_illegal;
    logic                  alloc_ready;
    logic [ROB_IDX_W-1:0]  alloc_idx;
    logic                  dp_rs_valid;
    alu_uop_t              dp_rs_uop;
    logic                  dp_rs_ready;
    logic                  rs_valid;
    alu_uop_t              rs_uop;
    logic                  rs_ready;
    logic                  wb_valid;
    logic [ROB_IDX_W-1:0]  wb_idx;
    vreg_t                 wb_data;
    logic                  vrf_we;
    logic [VREG_IDX_W-1:0] vrf_waddr;
    vreg_t                 vrf_wdata;

    rvv_fifo #(.T(logic [INST_W-1:0]), .DEPTH(CQ_DEPTH)) u_cmd_queue (
        .clk(clk), .rst_n(rst_n),
        .in_valid(inst_valid), .in_data(inst), .in_ready(inst_ready),
        .out_valid(cq_valid), .out_data(cq_inst), .out_ready(cq_ready)
    );

    rvv_decode u_decode (
        .cq_valid(cq_valid), .cq_inst(cq_inst), .cq_ready(cq_ready),
        .uq_valid(de_valid), .uq_uop(de_uop), .uq_ready(de_ready)
    );

    rvv_fifo #(.T(uop_t), .DEPTH(UQ_DEPTH)) u_uop_queue (
        .clk(clk), .rst_n(rst_n),
        .in_valid(de_valid), .in_data(de_uop), .in_ready(de_ready),
        .out_valid(uq_valid), .out_data(uq_uop), .out_ready(uq_ready)
    );

    rvv_dispatch u_dispatch (
        .clk(clk), .rst_n(rst_n),
        .uq_valid(uq_valid), .uq_uop(uq_uop), .uq_ready(uq_ready),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .pend_mask(pend_mask),
        .alloc_valid(alloc_valid), .alloc_vd(alloc_vd), .alloc_illegal(alloc_illegal),
        .alloc_ready(alloc_ready), .alloc_idx(alloc_idx),
        .rs_valid(dp_rs_valid), .rs_uop(dp_rs_uop), .rs_ready(dp_rs_ready)
    );

    rvv_fifo #(.T(alu_uop_t), .DEPTH(RS_DEPTH)) u_alu_rs (
        .clk(clk), .rst_n(rst_n),
        .in_valid(dp_rs_valid), .in_data(dp_rs_uop), .in_ready(dp_rs_ready),
        .out_valid(rs_valid), .out_data(rs_uop), .out_ready(rs_ready)
    );

    rvv_alu u_alu (
        .clk(clk), .rst_n(rst_n),
        .rs_valid(rs_valid), .rs_uop(rs_uop), .rs_ready(rs_ready),
        .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data)
    );

    rvv_rob u_rob (
        .clk(clk), .rst_n(rst_n),
        .alloc_valid(alloc_valid), .alloc_vd(alloc_vd), .alloc_illegal(alloc_illegal),
        .alloc_ready(alloc_ready), .alloc_idx(alloc_idx),
        .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data),
        .pend_mask(pend_mask),
        .vrf_we(vrf_we), .vrf_waddr(vrf_waddr), .vrf_wdata(vrf_wdata),
        .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_illegal(rt_illegal),
        .rt_data(rt_data), .rt_ready(rt_ready)
    );

    rvv_vrf u_vrf (
        .clk(clk), .rst_n(rst_n),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .we(vrf_we), .waddr(vrf_waddr), .wdata(vrf_wdata)
    );

endmodule

// ==== design/rvv_decode.sv ====
`timescale 1ns/1ps

module rvv_decode (
    input  logic                        cq_valid,
    input  logic [rvv_pkg::INST_W-1:0]  cq_inst,
    output logic                        cq_ready,
    output logic                        uq_valid,
    output rvv_pkg::uop_t               uq_uop,
    input  logic                        uq_ready
);

    import rvv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    logic       funct6_ok;

    assign opcode = cq_inst[6:0];
    assign funct3 = cq_inst[14:12];
    assign funct6 = cq_inst[31:26];

    always_comb begin
        funct6_ok = 1'b1;
        uq_uop.op = ALU_ADD;
        case (funct6)
            FUNCT6_ADD:  uq_uop.op = ALU_ADD;
            FUNCT6_SUB:  uq_uop.op = ALU_SUB;
            FUNCT6_MINU: uq_uop.op = ALU_MINU;
            FUNCT6_MAXU: uq_uop.op = ALU_MAXU;
            FUNCT6_AND:  uq_uop.op = ALU_AND;
            FUNCT6_OR:   uq_uop.op = ALU_OR;
            FUNCT6_XOR:  uq_uop.op = ALU_XOR;
            default:     funct6_ok = 1'b0;
        endcase
    end

    assign uq_uop.vd      = cq_inst[11:7];
    assign uq_uop.vs1     = cq_inst[19:15];
    assign uq_uop.vs2     = cq_inst[24:20];
    assign uq_uop.illegal = (opcode != OPV_OPCODE) || (funct3 != OPIVV_FUNCT3) || !funct6_ok;

    // No storage here, handshake passes straight through
    assign uq_valid = cq_valid;
    assign cq_ready = uq_ready;

endmodule

// ==== design/rvv_dispatch.sv ====
`timescale 1ns/1ps

module rvv_dispatch (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            uq_valid,
    input  rvv_pkg::uop_t                   uq_uop,
    output logic                            uq_ready,
    output logic [rvv_pkg::VREG_IDX_W-1:0]  rd_idx_a,
    output logic [rvv_pkg::VREG_IDX_W-1:0]  rd_idx_b,
    input  rvv_pkg::vreg_t                  rd_data_a,
    input  rvv_pkg::vreg_t                  rd_data_b,
    input  logic [rvv_pkg::NUM_VREG-1:0]    pend_mask,
    output logic                            alloc_valid,
    output logic [rvv_pkg::VREG_IDX_W-1:0]  alloc_vd,
    output logic                            alloc_illegal,
    input  logic                            alloc_ready,
    input  logic [rvv_pkg::ROB_IDX_W-1:0]   alloc_idx,
    output logic                            rs_valid,
    output rvv_pkg::alu_uop_t               rs_uop,
    input  logic                            rs_ready
);

    import rvv_pkg::*;

    logic        raw_hazard;
    logic        can_issue;
    logic        issue;

    // vs2 on port a, vs1 on port b
    assign rd_idx_a = uq_uop.vs2;
    assign rd_idx_b = uq_uop.vs1;

    assign raw_hazard = pend_mask[uq_uop.vs1] || pend_mask[uq_uop.vs2];

    // Illegal uops bypass the ALU and only take a ROB slot
    assign can_issue = uq_uop.illegal ? alloc_ready
                                      : (alloc_ready && !raw_hazard && rs_ready);
    assign issue = uq_valid && can_issue;

    assign uq_ready      = issue;
    assign alloc_valid   = issue;
    assign alloc_vd      = uq_uop.vd;
    assign alloc_illegal = uq_uop.illegal;

    assign rs_valid        = issue && !uq_uop.illegal;
    assign rs_uop.rob_idx  = alloc_idx;
    assign rs_uop.op       = uq_uop.op;
    assign rs_uop.vs1_data = rd_data_b;
    assign rs_uop.vs2_data = rd_data_a;

endmodule

// ==== design/rvv_fifo.sv ====
`timescale 1ns/1ps

module rvv_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,
    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             active;
    logic             push;
    logic             pop;

    // Held off until the first cycle out of reset
    assign in_ready  = active && (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/rvv_pkg.sv ====
package rvv_pkg;

    // Register geometry
    localparam int VLEN       = 128;
    localparam int ELEM_W     = 8;
    localparam int NUM_ELEM   = VLEN / ELEM_W;
    localparam int NUM_VREG   = 32;
    localparam int VREG_IDX_W = 5;
    localparam int INST_W     = 32;

    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX_W = 3;

    // Default queue depths
    localparam int CQ_DEPTH_DEF = 4;
    localparam int UQ_DEPTH_DEF = 4;
    localparam int RS_DEPTH_DEF = 4;

    // OPIVV encoding
    localparam logic [6:0] OPV_OPCODE   = 7'b1010111;
    localparam logic [2:0] OPIVV_FUNCT3 = 3'b000;

    localparam logic [5:0] FUNCT6_ADD  = 6'b000000;
    localparam logic [5:0] FUNCT6_SUB  = 6'b000010;
    localparam logic [5:0] FUNCT6_MINU = 6'b000100;
    localparam logic [5:0] FUNCT6_MAXU = 6'b000110;
    localparam logic [5:0] FUNCT6_AND  = 6'b001001;
    localparam logic [5:0] FUNCT6_OR   = 6'b001010;
    localparam logic [5:0] FUNCT6_XOR  = 6'b001011;

    typedef logic [VLEN-1:0] vreg_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_MINU = 3'd5,
        ALU_MAXU = 3'd6
    } alu_op_e;

    typedef struct packed {
        logic [VREG_IDX_W-1:0] vd;
        logic [VREG_IDX_W-1:0] vs1;
        logic [VREG_IDX_W-1:0] vs2;
        alu_op_e               op;
        logic                  illegal;
    } uop_t;

    // Reservation station entry, operands already read
    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        alu_op_e              op;
        vreg_t                vs1_data;
        vreg_t                vs2_data;
    } alu_uop_t;

endpackage

// ==== design/rvv_rob.sv ====
`timescale 1ns/1ps

module rvv_rob (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            alloc_valid,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]  alloc_vd,
    input  logic                            alloc_illegal,
    output logic                            alloc_ready,
    output logic [rvv_pkg::ROB_IDX_W-1:0]   alloc_idx,
    input  logic                            wb_valid,
    input  logic [rvv_pkg::ROB_IDX_W-1:0]   wb_idx,
    input  rvv_pkg::vreg_t                  wb_data,
    output logic [rvv_pkg::NUM_VREG-1:0]    pend_mask,
    output logic                            vrf_we,
    output logic [rvv_pkg::VREG_IDX_W-1:0]  vrf_waddr,
    output rvv_pkg::vreg_t                  vrf_wdata,
    output logic                            rt_valid,
    output logic [rvv_pkg::VREG_IDX_W-1:0]  rt_vd,
    output logic                            rt_illegal,
    output rvv_pkg::vreg_t                  rt_data,
    input  logic                            rt_ready
);

    import rvv_pkg::*;

    logic [ROB_DEPTH-1:0]  ent_valid;
    logic [ROB_DEPTH-1:0]  ent_done;
    logic [ROB_DEPTH-1:0]  ent_illegal;
    logic [VREG_IDX_W-1:0] ent_vd   [ROB_DEPTH];
    vreg_t                 ent_data [ROB_DEPTH];

    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    logic [ROB_IDX_W:0]   count;
    logic                 alloc;
    logic                 retire;

    assign alloc_ready = (count != (ROB_IDX_W + 1)'(ROB_DEPTH));
    assign alloc_idx   = tail;
    assign alloc       = alloc_valid && alloc_ready;

    assign rt_valid   = ent_valid[head] && ent_done[head];
    assign rt_vd      = ent_vd[head];
    assign rt_illegal = ent_illegal[head];
    assign rt_data    = ent_data[head];
    assign retire     = rt_valid && rt_ready;

    assign vrf_we    = retire && !ent_illegal[head];
    assign vrf_waddr = ent_vd[head];
    assign vrf_wdata = ent_data[head];

    // Head stays in the mask until its retire cycle
    always_comb begin
        pend_mask = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (ent_valid[i] && !ent_illegal[i]) begin
                pend_mask[ent_vd[i]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid <= '0;
            ent_done  <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            if (retire) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (wb_valid) begin
                ent_done[wb_idx] <= 1'b1;
            end
            if (alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= alloc_illegal;
                tail            <= tail + 1'b1;
            end
            if (alloc && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !alloc) begin
                count <= count - 1'b1;
            end
        end
    end

    // Payload fields
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            ent_data[wb_idx] <= wb_data;
        end
        if (alloc) begin
            ent_vd[tail]      <= alloc_vd;
            ent_illegal[tail] <= alloc_illegal;
            if (alloc_illegal) begin
                ent_data[tail] <= '0;
            end
        end
    end

endmodule

// ==== design/rvv_vrf.sv ====
`timescale 1ns/1ps

module rvv_vrf (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]  rd_idx_a,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]  rd_idx_b,
    output rvv_pkg::vreg_t                  rd_data_a,
    output rvv_pkg::vreg_t                  rd_data_b,
    input  logic                            we,
    input  logic [rvv_pkg::VREG_IDX_W-1:0]  waddr,
    input  rvv_pkg::vreg_t                  wdata
);

    import rvv_pkg::*;

    vreg_t regs [NUM_VREG];

    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Byte k of register r holds 16*r + k
            for (int r = 0; r < NUM_VREG; r++) begin
                for (int k = 0; k < NUM_ELEM; k++) begin
                    regs[r][k*ELEM_W +: ELEM_W] <= ELEM_W'(16 * r + k);
                end
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== dv/rvv_backend_asserts.sv ====
`timescale 1ns/1ps

module rvv_backend_asserts (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            inst_ready,
    input logic                            rt_valid,
    input logic                            rt_ready,
    input logic [rvv_pkg::VREG_IDX_W-1:0]  rt_vd,
    input logic                            rt_illegal,
    input rvv_pkg::vreg_t                  rt_data
);

    import rvv_pkg::*;

    // Checked on the cycle after each reset edge
    rt_valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !rt_valid)
        else $error("rt_valid high while reset is held");

    inst_ready_low_in_reset: assert property (@(posedge clk) !rst_n |=> !inst_ready)
        else $error("inst_ready high while reset is held");

    // Retire payload holds while stalled
    rt_stable_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && !rt_ready |=> rt_valid && $stable(rt_vd) && $stable(rt_illegal)
                                 && $stable(rt_data))
        else $error("retire output changed while rt_ready was low");

endmodule

bind rvv_backend rvv_backend_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .inst_ready(inst_ready),
    .rt_valid(rt_valid), .rt_ready(rt_ready), .rt_vd(rt_vd),
    .rt_illegal(rt_illegal), .rt_data(rt_data)
);

// ==== dv/rvv_backend_tb.sv ====
`timescale 1ns/1ps

module rvv_backend_tb;

    import rvv_pkg::*;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_RECORDS  = 64;
    localparam int DRAIN_CYCLES = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [INST_W-1:0]     inst;
    logic                  inst_ready;
    logic                  rt_valid;
    logic [VREG_IDX_W-1:0] rt_vd;
    vreg_t                 rt_data;
    logic                  rt_illegal;
    logic                  rt_ready;

    logic [INST_W-1:0]     rec_inst    [MAX_RECORDS];
    logic [VREG_IDX_W-1:0] rec_vd      [MAX_RECORDS];
    logic                  rec_illegal [MAX_RECORDS];
    vreg_t                 rec_data    [MAX_RECORDS];
    int                    num_recs;
    int                    num_sent;
    int                    num_retired;
    logic [15:0]           lfsr;

    rvv_backend DUT (
        .clk(clk), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
        .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data),
        .rt_illegal(rt_illegal), .rt_ready(rt_ready)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [VLEN-1:0] expected,
                               logic [VLEN-1:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: expected %0h, actual %0h",
                                     name, expected, actual));
        end
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic next_bit();
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return lfsr[0];
    endfunction

    // Long retire stalls in the middle of the run
    function automatic logic in_stall_window(int cyc);
        return (cyc >= 30 && cyc < 90) || (cyc >= 110 && cyc < 160);
    endfunction

    task automatic load_records();
        int                fd;
        int                code;
        string             line;
        logic [INST_W-1:0] word;
        logic [7:0]        vd;
        logic [7:0]        illegal;
        vreg_t             data;
        fd = $fopen("dv/rvv_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("could not open dv/rvv_stimulus.txt");
        end
        num_recs = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h", word, vd, illegal, data) == 4) begin
                    if (num_recs >= MAX_RECORDS) begin
                        report_failure("stimulus file holds more records than the table");
                    end
                    rec_inst[num_recs]    = word;
                    rec_vd[num_recs]      = vd[VREG_IDX_W-1:0];
                    rec_illegal[num_recs] = illegal[0];
                    rec_data[num_recs]    = data;
                    num_recs++;
                end
            end
        end
        $fclose(fd);
        if (num_recs == 0) begin
            report_failure("stimulus file holds no records");
        end
    endtask

    // Transfers are judged at the falling edge, inputs change 1 ns after the rising edge
    task automatic drive_stimulus();
        int   cyc;
        logic accepted;
        cyc = 0;
        forever begin
            @(negedge clk);
            accepted = inst_valid && inst_ready;
            @(posedge clk);
            #1;
            cyc++;
            if (accepted) begin
                num_sent++;
            end
            if (!inst_valid || accepted) begin
                if (num_sent < num_recs && next_bit()) begin
                    inst_valid = 1'b1;
                    inst       = rec_inst[num_sent];
                end else begin
                    inst_valid = 1'b0;
                end
            end
            if (in_stall_window(cyc)) begin
                rt_ready = 1'b0;
            end else begin
                rt_ready = next_bit();
            end
        end
    endtask

    task automatic run_watchdog();
        repeat (num_recs * 200) @(posedge clk);
        report_failure($sformatf("timeout: retires stopped after %0d of %0d instructions",
                                 num_retired, num_recs));
    endtask

    // Retire monitor
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && rt_valid && rt_ready) begin
                if (num_retired >= num_sent) begin
                    report_failure("retire seen with no accepted instruction outstanding");
                end
                check_value($sformatf("record %0d rt_vd", num_retired),
                            VLEN'(rec_vd[num_retired]), VLEN'(rt_vd));
                check_value($sformatf("record %0d rt_illegal", num_retired),
                            VLEN'(rec_illegal[num_retired]), VLEN'(rt_illegal));
                check_value($sformatf("record %0d rt_data", num_retired),
                            rec_data[num_retired], rt_data);
                num_retired++;
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        rt_ready    = 1'b0;
        lfsr        = 16'd18100;
        num_sent    = 0;
        num_retired = 0;
        load_records();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("reset inst_ready", '0, VLEN'(inst_ready));
            check_value("reset rt_valid", '0, VLEN'(rt_valid));
        end
        rst_n = 1'b1;
        fork
            drive_stimulus();
            run_watchdog();
        join_none
        wait (num_retired == num_recs);
        // Idle tail catches duplicate retires
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== dv/rvv_stimulus.txt ====
# Columns: instruction word, expected rt_vd, expected rt_illegal, expected rt_data
# All hex; rt_data is byte 15 first, byte 0 last
2A3181D7 03 0 3f3e3d3c3b3a39383736353433323130
2A738557 0a 0 7f7e7d7c7b7a79787776757473727170
2BFF8FD7 1f 0 fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0
2B080857 10 0 0f0e0d0c0b0a09080706050403020100
022085D7 0b 0 4e4c4a48464442403e3c3a3836343230
02F40657 0c 0 8e8c8a88868482807e7c7a7876747270
0A4086D7 0d 0 30303030303030303030303030303030
0A120757 0e 0 d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0
128387D7 0f 0 7f7e7d7c7b7a79787776757473727170
1A740857 10 0 8f8e8d8c8b8a89888786858483828180
265188D7 11 0 1f1e1d1c1b1a19181716151413121110
2A518957 12 0 7f7e7d7c7b7a79787776757473727170
2E5189D7 13 0 60606060606060606060606060606060
02B58A57 14 0 9c9894908c8884807c7874706c686460
0B408A57 14 0 7d7a7774716e6b6865625f5c59565350
13498AD7 15 0 606060606060606060605f5c59565350
035A8AD7 15 0 c0c0c0c0c0c0c0c0c0c0beb8b2aca6a0
2B5A8B57 16 0 c0c0c0c0c0c0c0c0c0c0beb8b2aca6a0
021101D3 03 1 00000000000000000000000000000000
022115D7 0b 1 00000000000000000000000000000000
FE108657 0c 1 00000000000000000000000000000000
2A318BD7 17 0 3f3e3d3c3b3a39383736353433323130
2AB58C57 18 0 4e4c4a48464442403e3c3a3836343230
2AC60CD7 19 0 8e8c8a88868482807e7c7a7876747270
03E10D57 1a 0 1e1c1a18161412100e0c0a0806040200
0BA00D57 1a 0 0f0e0d0c0b0a09080706050403020100
1BA80DD7 1b 0 8f8e8d8c8b8a89888786858483828180
13BF8E57 1c 0 8f8e8d8c8b8a89888786858483828180
2FCD0ED7 1d 0 80808080808080808080808080808080
27D604D7 09 0 80808080808080800000000000000000
FE9484D7 09 1 00000000000000000000000000000000
2A948357 06 0 80808080808080800000000000000000
2E000057 00 0 00000000000000000000000000000000
02070057 00 0 d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0d0
0A0680D7 01 0 a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0a0
2F1902D7 05 0 60606060606060606060606060606060
023183D7 07 0 7e7c7a78767472706e6c6a6866646260
